// File: build.f
verilog/pip_types_pkg.sv
verilog/idec.sv
verilog/id.sv
verilog/rob_alloc.sv
verilog/iq.sv
verilog/dispatch_top.sv
tb/dispatch_checker.sv
tb/tb_dispatch.sv

// File: Bender.yml
package:
  name: dispatch

sources:
  - verilog/pip_types_pkg.sv
  - verilog/idec.sv
  - verilog/id.sv
  - verilog/rob_alloc.sv
  - verilog/iq.sv
  - verilog/dispatch_top.sv
  - target: test
    files:
      - tb/dispatch_checker.sv
      - tb/tb_dispatch.sv

// File: tb/tb_dispatch.sv
`timescale 1ns/100ps

module tb_dispatch
  import pip_types_pkg::*;
();

  localparam int total_bundles = 400;
  localparam int cycle_limit   = total_bundles * 20 + 200;
  // alu_reg, alu_imm, load, store, branch, jal, jalr, lui, auipc, then a custom opcode.
  localparam logic [9:0][6:0] opc_tab = {7'h0b, 7'h17, 7'h37, 7'h67, 7'h6f,
                                         7'h63, 7'h23, 7'h03, 7'h13, 7'h33};

  logic          clk;
  logic          rst;
  fetch_bundle_t fetch_bundle;
  logic          fetch_valid;
  logic          fetch_ready;
  logic          commit;
  logic          issue_valid;
  logic          issue_ready;
  iq_entry_t     issue_entry;
  logic [31:0]   lcg_state;
  rob_slot_t     next_slot;
  int            cycles;
  int            stall_cycles;

  dispatch_top i_dispatch_top (
    .clk          (clk),
    .rst          (rst),
    .fetch_bundle (fetch_bundle),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .commit       (commit),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_entry  (issue_entry)
  );

  dispatch_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_mask  (fetch_bundle.valid),
    .commit      (commit),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_entry (issue_entry)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic bit chance(input int pct);
    return (lcg_next() % 100) < pct;
  endfunction

  function automatic logic [31:0] gen_word(input int base, input int span);
    logic [31:0] w;
    w      = {lcg_next(), lcg_next()};
    w[6:0] = opc_tab[base + (lcg_next() % span)];
    if (lcg_next() % 4 == 0) begin
      w[11:7] = 5'd0;
    end
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference decode from the rv32i bit layout.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic dec_inst_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
    dec_inst_t d;
    logic      wr;
    d.pc       = pc;
    d.rd       = w[11:7];
    d.rs1      = w[19:15];
    d.rs2      = w[24:20];
    d.funct3   = w[14:12];
    d.imm      = 32'd0;
    d.op_class = illegal;
    wr         = 1'b0;
    case (w[6:0])
      7'h33: begin
        d.op_class = alu_reg;
        wr         = 1'b1;
      end
      7'h13, 7'h03, 7'h67: begin
        d.op_class = (w[6:0] == 7'h13) ? alu_imm : (w[6:0] == 7'h03) ? load : jump;
        d.imm      = {{20{w[31]}}, w[31:20]};
        wr         = 1'b1;
      end
      7'h23: begin
        d.op_class = store;
        d.imm      = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'h63: begin
        d.op_class = branch;
        d.imm      = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      7'h6f: begin
        d.op_class = jump;
        d.imm      = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        wr         = 1'b1;
      end
      7'h37, 7'h17: begin
        d.op_class = upper;
        d.imm      = {w[31:12], 12'd0};
        wr         = 1'b1;
      end
      default: begin
        d.op_class = illegal;
      end
    endcase
    d.dest_reg_valid = wr && (w[11:7] != 5'd0);
    return d;
  endfunction

  // one expected entry per valid lane of an accepted bundle.
  always @(posedge clk) begin : model_push
    iq_entry_t exp_entry;
    if (rst) begin
      next_slot = '0;
    end else if (fetch_valid && fetch_ready) begin
      for (int k = 0; k < lanes; k++) begin
        if (fetch_bundle.valid[k]) begin
          exp_entry.rob_slot = next_slot;
          exp_entry.dec_inst = ref_decode(fetch_bundle.word[k], fetch_bundle.pc[k]);
          i_checker.expect_entry(exp_entry);
          next_slot = next_slot + 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d expected entries never issued",
               cycle_limit, i_checker.pending_count());
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic run_test(input int num, input string name, input int bundles,
                          input int base, input int span, input bit full,
                          input int ready_pct, input int commit_pct, input bit need_stall);
    int          accepted;
    int          err0;
    int          iss0;
    bit          holding;
    logic [31:0] pc_base;
    accepted     = 0;
    holding      = 1'b0;
    stall_cycles = 0;
    err0         = i_checker.error_count();
    iss0         = i_checker.issue_count();
    while (accepted < bundles) begin
      @(negedge clk);
      issue_ready = chance(ready_pct);
      commit      = chance(commit_pct);
      // a stalled bundle is held unchanged.
      if (!holding) begin
        fetch_valid = chance(70);
        if (fetch_valid) begin
          pc_base = {lcg_next(), lcg_next()} & ~32'hf;
          for (int k = 0; k < lanes; k++) begin
            fetch_bundle.word[k] = gen_word(base, span);
            fetch_bundle.pc[k]   = pc_base + 32'(4 * k);
          end
          fetch_bundle.valid = full ? 4'hf : 4'(lcg_next());
          holding = 1'b1;
        end
      end
      if (!fetch_ready) begin
        stall_cycles++;
      end
      if (holding && fetch_ready) begin
        accepted++;
        holding = 1'b0;
      end
    end
    @(negedge clk);
    fetch_valid = 1'b0;
    commit      = 1'b0;
    issue_ready = 1'b1;
    while (i_checker.pending_count() != 0) begin
      @(negedge clk);
    end
    // one more edge lets the monitor see a stray entry.
    @(negedge clk);
    if (need_stall && stall_cycles == 0) begin
      i_checker.note_failure($sformatf("test %0d never saw fetch_ready go low", num));
    end
    $display("test %0d %s: %0d bundles, %0d issued, %0d errors", num, name, bundles,
             i_checker.issue_count() - iss0, i_checker.error_count() - err0);
  endtask

  initial begin
    lcg_state    = 32'd65;
    cycles       = 0;
    rst          = 1'b1;
    fetch_bundle = '0;
    fetch_valid  = 1'b0;
    commit       = 1'b0;
    issue_ready  = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    i_checker.check_reset_state();
    $display("test 1 reset state: %0d errors", i_checker.error_count());
    run_test(2, "full bundles", 100, 0, 2, 1'b1, 100, 90, 1'b0);
    run_test(3, "sparse masks", 100, 0, 4, 1'b0, 100, 90, 1'b0);
    run_test(4, "decode mix", 100, 0, 10, 1'b1, 100, 90, 1'b0);
    run_test(5, "issue back-pressure", 60, 0, 9, 1'b1, 25, 90, 1'b1);
    run_test(6, "rob full", 40, 0, 9, 1'b0, 90, 10, 1'b1);
    $display("6 tests, %0d entries issued, %0d errors",
             i_checker.issue_count(), i_checker.error_count());
    if (i_checker.error_count() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb/dispatch_checker.sv
`timescale 1ns/100ps

module dispatch_checker
  import pip_types_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       fetch_valid,
  input logic       fetch_ready,
  input logic [3:0] fetch_mask,
  input logic       commit,
  input logic       issue_valid,
  input logic       issue_ready,
  input iq_entry_t  issue_entry
);

  iq_entry_t exp_q[$];
  int        errors = 0;
  int        issued = 0;
  int        iq_cnt;
  int        rob_occ;
  logic      rob_full_m;

  function automatic int pending_count();
    return exp_q.size();
  endfunction

  function automatic int error_count();
    return errors;
  endfunction

  function automatic int issue_count();
    return issued;
  endfunction

  task automatic expect_entry(input iq_entry_t e);
    exp_q.push_back(e);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
    end
  endtask

  task automatic check_reset_state();
    check_field("issue_valid after reset", 32'd0, issue_valid);
    check_field("fetch_ready after reset", 32'd1, fetch_ready);
  endtask

  task automatic compare_entry(input iq_entry_t exp, input iq_entry_t got);
    check_field("rob_slot", exp.rob_slot, got.rob_slot);
    check_field("pc", exp.dec_inst.pc, got.dec_inst.pc);
    check_field("op_class", exp.dec_inst.op_class, got.dec_inst.op_class);
    check_field("rd", exp.dec_inst.rd, got.dec_inst.rd);
    check_field("rs1", exp.dec_inst.rs1, got.dec_inst.rs1);
    check_field("rs2", exp.dec_inst.rs2, got.dec_inst.rs2);
    check_field("dest_reg_valid", exp.dec_inst.dest_reg_valid, got.dec_inst.dest_reg_valid);
    check_field("imm", exp.dec_inst.imm, got.dec_inst.imm);
    check_field("funct3", exp.dec_inst.funct3, got.dec_inst.funct3);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flow control model and issue port compare.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin : monitor
    int n;
    bit fire;
    if (rst) begin
      iq_cnt     = 0;
      rob_occ    = 0;
      rob_full_m = 1'b0;
    end else begin
      check_field("fetch_ready", !(rob_full_m || iq_cnt > iq_depth - lanes), fetch_ready);
      check_field("issue_valid", iq_cnt != 0, issue_valid);
      fire = issue_valid && issue_ready;
      if (fire) begin
        issued++;
        if (exp_q.size() == 0) begin
          note_failure($sformatf("unexpected issue at %0t with no entry expected", $time));
        end else begin
          compare_entry(exp_q.pop_front(), issue_entry);
        end
      end
      n = (fetch_valid && fetch_ready) ? $countones(fetch_mask) : 0;
      iq_cnt = iq_cnt + n - (fire ? 1 : 0);
      // commit looks at the occupancy before this edge.
      if (commit && rob_occ != 0) begin
        rob_occ = rob_occ - 1;
      end
      rob_occ    = rob_occ + n;
      rob_full_m = rob_occ > rob_full_limit;
    end
  end

endmodule

// File: verilog/dispatch_top.sv
`timescale 1ns/100ps

module dispatch_top
  import pip_types_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  fetch_bundle_t fetch_bundle,
  input  logic          fetch_valid,
  output logic          fetch_ready,
  input  logic          commit,
  output logic          issue_valid,
  input  logic          issue_ready,
  output iq_entry_t     issue_entry
);

  logic                  stall;
  logic                  reserve;
  logic [1:0]            reserve_count;
  rob_slot_t [lanes-1:0] reserved_slots;
  logic                  rob_full;
  logic                  ins_enable;
  logic [1:0]            new_count;
  iq_entry_t [lanes-1:0] new_elements;
  logic                  iq_full;

  assign fetch_ready = ~stall;

  id i_id (
    .bundle         (fetch_bundle),
    .bundle_valid   (fetch_valid),
    .stall          (stall),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full),
    .ins_enable     (ins_enable),
    .new_count      (new_count),
    .new_elements   (new_elements),
    .iq_full        (iq_full)
  );

  rob_alloc i_rob_alloc (
    .clk            (clk),
    .rst            (rst),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .commit         (commit),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full)
  );

  iq i_iq (
    .clk            (clk),
    .rst            (rst),
    .ins_enable     (ins_enable),
    .new_count      (new_count),
    .new_elements   (new_elements),
    .issue_ready    (issue_ready),
    .iq_full        (iq_full),
    .issue_valid    (issue_valid),
    .issue_entry    (issue_entry)
  );

endmodule

// File: verilog/iq.sv
`timescale 1ns/100ps

module iq
  import pip_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ins_enable,
  input  logic [1:0]            new_count,
  input  iq_entry_t [lanes-1:0] new_elements,
  input  logic                  issue_ready,
  output logic                  iq_full,
  output logic                  issue_valid,
  output iq_entry_t             issue_entry
);

  typedef logic [iq_ptr_w-1:0] iq_ptr_t;

  iq_entry_t           mem [iq_depth];
  iq_ptr_t             head;
  iq_ptr_t             tail;
  logic [iq_ptr_w:0]   count;
  logic [iq_ptr_w:0]   ins_num;
  logic                issue_fire;

  // head entry is always on the issue port.
  assign issue_valid = count != '0;
  assign issue_entry = mem[head];
  assign issue_fire  = issue_valid & issue_ready;

  // needs room for a whole bundle.
  assign iq_full     = (iq_depth - count) < lanes;

  assign ins_num     = ins_enable ? (iq_ptr_w + 1)'(new_count) + 1'b1 : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (ins_enable) begin
      for (int k = 0; k < lanes; k++) begin
        if (k <= new_count) begin
          mem[iq_ptr_t'(tail + iq_ptr_t'(k))] <= new_elements[k];
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointers and count.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (ins_enable) begin
        tail <= iq_ptr_t'(tail + ins_num);
      end
      if (issue_fire) begin
        head <= iq_ptr_t'(head + 1'b1);
      end
      count <= count + ins_num - (issue_fire ? 1'b1 : 1'b0);
    end
  end

endmodule

// File: verilog/rob_alloc.sv
`timescale 1ns/100ps

module rob_alloc
  import pip_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reserve,
  input  logic [1:0]            reserve_count,
  input  logic                  commit,
  output rob_slot_t [lanes-1:0] reserved_slots,
  output logic                  rob_full
);

  rob_slot_t                 tail;
  logic [rob_depth_log2:0]   occupancy;
  logic [rob_depth_log2:0]   occupancy_next;
  logic [rob_depth_log2:0]   add_count;
  logic                      commit_eff;

  // consecutive slots from the tail wrap modulo the rob size.
  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      reserved_slots[k] = rob_slot_t'(tail + rob_slot_t'(k));
    end
  end

  assign commit_eff     = commit && (occupancy != '0);
  assign add_count      = reserve ? (rob_depth_log2 + 1)'(reserve_count) + 1'b1 : '0;
  assign occupancy_next = occupancy + add_count - (commit_eff ? 1'b1 : 1'b0);

  always_ff @(posedge clk) begin
    if (rst) begin
      tail      <= '0;
      occupancy <= '0;
      rob_full  <= 1'b0;
    end else begin
      if (reserve) begin
        tail <= rob_slot_t'(tail + rob_slot_t'(reserve_count) + 1'b1);
      end
      occupancy <= occupancy_next;
      rob_full  <= occupancy_next > rob_full_limit;
    end
  end

endmodule

// File: verilog/id.sv
`timescale 1ns/100ps

module id
  import pip_types_pkg::*;
(
  input  fetch_bundle_t               bundle,
  input  logic                        bundle_valid,
  output logic                        stall,

  // rob reservation.
  output logic                        reserve,
  output logic [1:0]                  reserve_count,
  input  rob_slot_t [lanes-1:0]       reserved_slots,
  input  logic                        rob_full,

  // issue queue write.
  output logic                        ins_enable,
  output logic [1:0]                  new_count,
  output iq_entry_t [lanes-1:0]       new_elements,
  input  logic                        iq_full
);

  dec_inst_t [lanes-1:0] dec_inst;
  logic [2:0]            valid_count;
  logic                  any_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one decoder per lane.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar g = 0; g < lanes; g++) begin : g_dec
    idec i_idec (
      .pc        (bundle.pc[g]),
      .inst_word (bundle.word[g]),
      .di        (dec_inst[g])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compaction toward lane 0.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      new_elements[k].rob_slot = reserved_slots[k];
      new_elements[k].dec_inst = '0;
    end

    // running count doubles as the next free output lane.
    valid_count = 3'd0;
    for (int i = 0; i < lanes; i++) begin
      if (bundle.valid[i]) begin
        new_elements[valid_count[1:0]].dec_inst = dec_inst[i];
        valid_count = valid_count + 3'd1;
      end
    end
  end

  assign any_valid     = |bundle.valid;

  // count minus one; wraps for an empty bundle but is then unused.
  assign reserve_count = 2'(valid_count - 3'd1);
  assign new_count     = reserve_count;

  assign stall         = rob_full | iq_full;
  assign reserve       = ~stall & bundle_valid & any_valid;
  assign ins_enable    = reserve;

endmodule

// File: verilog/idec.sv
`timescale 1ns/100ps

module idec
  import pip_types_pkg::*;
(
  input  logic [31:0] pc,
  input  inst_fmt_u   inst_word,
  output dec_inst_t   di
);

  logic writes_rd;

  always_comb begin
    di.pc       = pc;
    di.op_class = illegal;
    // register fields sit at the same place in every format.
    di.rd       = inst_word.r_fmt.rd;
    di.rs1      = inst_word.r_fmt.rs1;
    di.rs2      = inst_word.r_fmt.rs2;
    di.funct3   = inst_word.r_fmt.funct3;
    di.imm      = '0;
    writes_rd   = 1'b0;

    case (inst_word.r_fmt.opcode)
      opc_op: begin
        di.op_class = alu_reg;
        writes_rd   = 1'b1;
      end
      opc_op_imm: begin
        di.op_class = alu_imm;
        di.imm      = {{20{inst_word.i_fmt.imm_11_0[11]}}, inst_word.i_fmt.imm_11_0};
        writes_rd   = 1'b1;
      end
      opc_load: begin
        di.op_class = load;
        di.imm      = {{20{inst_word.i_fmt.imm_11_0[11]}}, inst_word.i_fmt.imm_11_0};
        writes_rd   = 1'b1;
      end
      opc_store: begin
        di.op_class = store;
        di.imm      = {{20{inst_word.s_fmt.imm_11_5[6]}},
                       inst_word.s_fmt.imm_11_5,
                       inst_word.s_fmt.imm_4_0};
      end
      opc_branch: begin
        di.op_class = branch;
        di.imm      = {{19{inst_word.b_fmt.imm_12}},
                       inst_word.b_fmt.imm_12,
                       inst_word.b_fmt.imm_11,
                       inst_word.b_fmt.imm_10_5,
                       inst_word.b_fmt.imm_4_1,
                       1'b0};
      end
      opc_jal: begin
        di.op_class = jump;
        di.imm      = {{11{inst_word.j_fmt.imm_20}},
                       inst_word.j_fmt.imm_20,
                       inst_word.j_fmt.imm_19_12,
                       inst_word.j_fmt.imm_11,
                       inst_word.j_fmt.imm_10_1,
                       1'b0};
        writes_rd   = 1'b1;
      end
      // jalr uses the i-type layout.
      opc_jalr: begin
        di.op_class = jump;
        di.imm      = {{20{inst_word.i_fmt.imm_11_0[11]}}, inst_word.i_fmt.imm_11_0};
        writes_rd   = 1'b1;
      end
      opc_lui, opc_auipc: begin
        di.op_class = upper;
        di.imm      = {inst_word.u_fmt.imm_31_12, 12'b0};
        writes_rd   = 1'b1;
      end
      default: begin
        di.op_class = illegal;
      end
    endcase

    // x0 is never a real destination.
    di.dest_reg_valid = writes_rd && (inst_word.r_fmt.rd != 5'd0);
  end

endmodule

// File: verilog/pip_types_pkg.sv
package pip_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizing.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int rob_depth_log2 = 4;
  // full above this, so a whole bundle still fits.
  localparam int rob_full_limit = 12;
  localparam int iq_depth       = 8;
  localparam int iq_ptr_w       = $clog2(iq_depth);
  localparam int lanes          = 4;

  // rv32i major opcodes.
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  typedef logic [rob_depth_log2-1:0] rob_slot_t;

  typedef enum logic [2:0] {
    alu_reg,
    alu_imm,
    load,
    store,
    branch,
    jump,
    upper,
    illegal
  } op_class_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one view of the instruction word per encoding.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_fmt_u;

  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op_class;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        dest_reg_valid;
    logic [31:0] imm;
    logic [2:0]  funct3;
  } dec_inst_t;

  typedef struct packed {
    rob_slot_t rob_slot;
    dec_inst_t dec_inst;
  } iq_entry_t;

  typedef struct packed {
    inst_fmt_u [lanes-1:0]       word;
    logic [lanes-1:0][31:0]      pc;
    logic [lanes-1:0]            valid;
  } fetch_bundle_t;

endpackage
